// File: dv/bru_properties.sv
`timescale 1ns/1ps

module bru_properties (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  ex_stall_i,
  input logic                  st_flush_i,
  input bru_pkg::insn_t        id_insn_i,
  input bru_pkg::xlen_t        nxt_pc_i,
  input logic                  flush_i,
  input logic                  cacheflush_i,
  input bru_pkg::exceptions_t  exceptions_i
);

  import bru_pkg::*;

  // Read by the testbench at the end of the run
  int unsigned assert_fails = 0;

  logic jalr_in_id;

  // JALR in decode that gets registered this cycle
  assign jalr_in_id = !id_insn_i.bubble && !ex_stall_i &&
                      (id_insn_i.instr[6:0] == OPC_JALR);

  // Cache flush always comes with a pipeline flush
  cacheflush_with_flush: assert property (
    @(posedge clk_i) disable iff (!rst_ni) cacheflush_i |-> flush_i
  ) else begin
    assert_fails++;
    $error("cacheflush_o set while flush_o is clear");
  end

  // JALR target has bit 0 cleared
  jalr_target_even: assert property (
    @(posedge clk_i) disable iff (!rst_ni) jalr_in_id |=> !nxt_pc_i[0]
  ) else begin
    assert_fails++;
    $error("nxt_pc_o bit 0 set after a JALR");
  end

  // Flushed instruction leaves no exception behind
  flush_clears_exc: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (st_flush_i && !ex_stall_i) |=> (exceptions_i == '0)
  ) else begin
    assert_fails++;
    $error("exceptions_o not clear after st_flush_i");
  end

endmodule

bind bru_top bru_properties i_properties (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .ex_stall_i   (ex_stall_i),
  .st_flush_i   (st_flush_i),
  .id_insn_i    (id_insn_i),
  .nxt_pc_i     (nxt_pc_o),
  .flush_i      (flush_o),
  .cacheflush_i (cacheflush_o),
  .exceptions_i (exceptions_o)
);

// File: dv/bru_tb.sv
`timescale 1ns/1ps
`include "bru_cfg.svh"

module bru_tb;

  import bru_pkg::*;

  typedef logic [`BP_PHT_BITS-1:0] pht_idx_t;

  // One expected execute-stage result and the cycle it is checked in
  typedef struct packed {
    int unsigned due;
    xlen_t       pc;
    logic        flush;
    logic        cflush;
    logic        taken;
    logic        update;
    exceptions_t exc;
  } exp_t;

  logic        clk_i;
  logic        rst_ni;
  logic        ex_stall_i;
  logic        st_flush_i;
  xlen_t       if_pc_i;
  insn_t       id_insn_i;
  exceptions_t id_exceptions_i;
  exceptions_t ex_exceptions_i;
  exceptions_t mem_exceptions_i;
  exceptions_t wb_exceptions_i;
  xlen_t       opa_i;
  xlen_t       opb_i;
  xlen_t       nxt_pc_o;
  logic        flush_o;
  logic        cacheflush_o;
  logic        bp_btaken_o;
  logic        bp_update_o;
  exceptions_t exceptions_o;

  // Model copy of the counter table and the speculative history
  bp_cnt_t                  pht_m [1 << `BP_PHT_BITS];
  logic [`BP_GLOBAL_BITS:0] hist_m;

  exp_t        exp_q [$];
  exp_t        cur_exp;
  bp_cnt_t     last_pred;
  int unsigned cycle_cnt = 0;
  int unsigned checks    = 0;
  int unsigned errors    = 0;
  // Taken conditional branches the DUT resolved without a flush
  int unsigned kept_pred = 0;
  logic [2:0]  f3_tab [6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};

  bru_top i_dut (.*);

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_pc(string what, xlen_t got, xlen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(string what, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_exc(string what, exceptions_t got, exceptions_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic pht_idx_t pht_index(xlen_t pc, bp_hist_t h);
    return pht_idx_t'(pc >> 2) ^ pht_idx_t'(h);
  endfunction

  function automatic xlen_t sign_extend(xlen_t v, int unsigned msb);
    return xlen_t'($signed(v << (`XLEN - 1 - msb)) >>> (`XLEN - 1 - msb));
  endfunction

  // Expected outputs for one decoded 32-bit instruction
  function automatic exp_t resolve_ref(opcode_e op, logic [2:0] f3, xlen_t pc, xlen_t imm,
                                       xlen_t opa, xlen_t opb, bp_cnt_t pred,
                                       exceptions_t id_exc, logic kill);
    exp_t r;
    logic cond;
    logic mis;
    r     = '0;
    r.pc  = pc + 4;
    r.exc = id_exc;
    case (branch_f3_e'(f3))
      BEQ:     cond = (opa == opb);
      BNE:     cond = (opa != opb);
      BLT:     cond = ($signed(opa) < $signed(opb));
      BGE:     cond = ($signed(opa) >= $signed(opb));
      BLTU:    cond = (opa < opb);
      BGEU:    cond = (opa >= opb);
      default: cond = 1'b0;
    endcase
    case (op)
      OPC_BRANCH: begin
        r.taken  = cond;
        r.update = 1'b1;
        r.flush  = cond ^ pred[1];
        r.pc     = cond ? pc + imm : pc + 4;
      end
      OPC_JAL: begin
        r.taken = 1'b1;
        r.flush = !pred[1];
        r.pc    = pc + imm;
      end
      OPC_JALR: begin
        r.taken = 1'b1;
        r.flush = 1'b1;
        r.pc    = (opa + opb) & ~xlen_t'(1);
      end
      OPC_MISC_MEM: begin
        r.flush  = (f3 == 3'b001);
        r.cflush = (f3 == 3'b001);
      end
      default: begin
      end
    endcase
    if (op inside {OPC_BRANCH, OPC_JAL, OPC_JALR}) begin
      mis = (`HAS_RVC != 0) ? r.pc[0] : (r.pc[1:0] != 2'b00);
      r.exc.misaligned_instruction = r.exc.misaligned_instruction | mis;
    end
    r.exc.any = r.exc.any | r.exc.misaligned_instruction;
    if (kill) begin
      r.exc = '0;
    end
    return r;
  endfunction

  // Saturating counter step and history shift after a conditional branch
  task automatic train_model(pht_idx_t idx, logic taken);
    if (taken && pht_m[idx] != 2'b11) begin
      pht_m[idx] = pht_m[idx] + 2'd1;
    end else if (!taken && pht_m[idx] != 2'b00) begin
      pht_m[idx] = pht_m[idx] - 2'd1;
    end
    hist_m = {hist_m[`BP_GLOBAL_BITS-1:0], taken};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] encode_insn(opcode_e op, logic [2:0] f3, xlen_t imm);
    case (op)
      OPC_BRANCH:   return {imm[12], imm[10:5], 10'h0, f3, imm[4:1], imm[11], 7'b1100011};
      OPC_JAL:      return {imm[20], imm[10:1], imm[11], imm[19:12], 5'h1, 7'b1101111};
      OPC_JALR:     return {17'h0, 3'b000, 5'h1, 7'b1100111};
      OPC_MISC_MEM: return {17'h0, f3, 5'h0, 7'b0001111};
      default:      return 32'h0000_0013;
    endcase
  endfunction

  function automatic exceptions_t make_exc(logic ill, logic bkpt);
    exceptions_t e;
    e                     = '0;
    e.illegal_instruction = ill;
    e.breakpoint          = bkpt;
    e.any                 = ill | bkpt;
    return e;
  endfunction

  // Mix of sign boundary values and plain random words
  function automatic xlen_t pick_operand();
    case ($urandom % 8)
      0:       return '0;
      1:       return 32'h0000_0001;
      2:       return 32'h7fff_ffff;
      3:       return 32'h8000_0000;
      4:       return 32'hffff_ffff;
      default: return xlen_t'($urandom);
    endcase
  endfunction

  function automatic xlen_t random_pc();
    return xlen_t'($urandom) & 32'h000f_fffc;
  endfunction

  task automatic go_idle();
    id_insn_i        = '{bubble: 1'b1, instr: 32'h0};
    id_exceptions_i  = '0;
    ex_exceptions_i  = '0;
    mem_exceptions_i = '0;
    wb_exceptions_i  = '0;
    st_flush_i       = 1'b0;
    opa_i            = '0;
    opb_i            = '0;
  endtask

  // Drives one decode-stage instruction and queues its expected result
  task automatic issue_insn(opcode_e op, logic [2:0] f3, xlen_t pc, xlen_t imm,
                            xlen_t opa, xlen_t opb, exceptions_t id_exc, logic st_flush,
                            exceptions_t late_exc, int late_stage, logic prev_flush);
    bp_hist_t h;
    exp_t     e;
    h                = hist_m[`BP_GLOBAL_BITS:1];
    last_pred        = pht_m[pht_index(pc, h)];
    id_insn_i        = '{bubble: 1'b0, instr: encode_insn(op, f3, imm)};
    id_exceptions_i  = id_exc;
    st_flush_i       = st_flush;
    opa_i            = opa;
    opb_i            = opb;
    if_pc_i          = pc + 4;
    case (late_stage)
      0:       ex_exceptions_i  = late_exc;
      1:       mem_exceptions_i = late_exc;
      default: wb_exceptions_i  = late_exc;
    endcase
    e     = resolve_ref(op, f3, pc, imm, opa, opb, last_pred, id_exc,
                        st_flush | late_exc.any | prev_flush);
    e.due = cycle_cnt + 1;
    exp_q.push_back(e);
    if (op == OPC_BRANCH) begin
      train_model(pht_index(pc, h), e.taken);
    end
  endtask

  // Fetch, decode, then two idle cycles so table and history settle
  task automatic run_insn(opcode_e op, logic [2:0] f3, xlen_t pc, xlen_t imm, xlen_t opa,
                          xlen_t opb, exceptions_t id_exc, logic st_flush,
                          exceptions_t late_exc, int late_stage);
    if_pc_i = pc;
    @(posedge clk_i);
    #1;
    issue_insn(op, f3, pc, imm, opa, opb, id_exc, st_flush, late_exc, late_stage, 1'b0);
    @(posedge clk_i);
    #1;
    go_idle();
    @(posedge clk_i);
    #1;
  endtask

  // JALR directly followed by an instruction whose exception it squashes
  task automatic flush_then_exc(xlen_t pc, xlen_t opa, xlen_t opb);
    if_pc_i = pc;
    @(posedge clk_i);
    #1;
    issue_insn(OPC_JALR, 3'b000, pc, '0, opa, opb, '0, 1'b0, '0, 0, 1'b0);
    @(posedge clk_i);
    #1;
    go_idle();
    issue_insn(OPC_OTHER, 3'b000, pc + 4, '0, '0, '0, make_exc(1'b1, 1'b0), 1'b0, '0, 0,
               1'b1);
    @(posedge clk_i);
    #1;
    go_idle();
    @(posedge clk_i);
    #1;
  endtask

  // Registered PC and exceptions hold while the stage stalls on a bubble
  task automatic stall_hold(xlen_t pc);
    exp_t e;
    if_pc_i = pc;
    @(posedge clk_i);
    #1;
    issue_insn(OPC_OTHER, 3'b000, pc, '0, '0, '0, make_exc(1'b1, 1'b0), 1'b0, '0, 0, 1'b0);
    e = exp_q[$];
    @(posedge clk_i);
    #1;
    go_idle();
    ex_stall_i      = 1'b1;
    id_exceptions_i = make_exc(1'b0, 1'b1);
    repeat (3) begin
      @(posedge clk_i);
      #1;
      check_pc("nxt_pc_o under stall", nxt_pc_o, e.pc);
      check_exc("exceptions_o under stall", exceptions_o, e.exc);
    end
    ex_stall_i = 1'b0;
    go_idle();
    @(posedge clk_i);
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare process at the falling edge where outputs are stable
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (exp_q.size() != 0 && exp_q[0].due == cycle_cnt) begin
      cur_exp = exp_q.pop_front();
      check_pc("nxt_pc_o", nxt_pc_o, cur_exp.pc);
      check_flag("flush_o", flush_o, cur_exp.flush);
      check_flag("cacheflush_o", cacheflush_o, cur_exp.cflush);
      check_flag("bp_btaken_o", bp_btaken_o, cur_exp.taken);
      check_flag("bp_update_o", bp_update_o, cur_exp.update);
      check_exc("exceptions_o", exceptions_o, cur_exp.exc);
      if (bp_update_o && bp_btaken_o && !flush_o) begin
        kept_pred++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    xlen_t       a;
    xlen_t       b;
    xlen_t       imm;
    int unsigned kept_before;
    int unsigned wait_cnt;
    void'($urandom(32'h849c));
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    ex_stall_i = 1'b0;
    if_pc_i    = xlen_t'(`PC_INIT);
    go_idle();
    for (int i = 0; i < (1 << `BP_PHT_BITS); i++) begin
      pht_m[i] = 2'b01;
    end
    hist_m = '0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // Pipeline restart state straight out of reset
    check_flag("flush_o after reset", flush_o, 1'b1);
    check_pc("nxt_pc_o after reset", nxt_pc_o, xlen_t'(`PC_INIT));

    // All six conditional kinds with some equal operands
    for (int i = 0; i < 36; i++) begin
      a   = pick_operand();
      b   = ($urandom % 4 == 0) ? a : pick_operand();
      imm = sign_extend(xlen_t'($urandom) & 32'h0000_1ffe, 12);
      run_insn(OPC_BRANCH, f3_tab[i % 6], random_pc(), imm, a, b, '0, 1'b0, '0, 0);
    end

    // JAL and JALR targets with a misaligned one of each
    for (int i = 0; i < 8; i++) begin
      imm = sign_extend(xlen_t'($urandom) & 32'h001f_fffc, 20);
      run_insn(OPC_JAL, 3'b000, random_pc(), imm, '0, '0, '0, 1'b0, '0, 0);
    end
    run_insn(OPC_JAL, 3'b000, 32'h0000_0800, 32'h0000_0102, '0, '0, '0, 1'b0, '0, 0);
    for (int i = 0; i < 8; i++) begin
      run_insn(OPC_JALR, 3'b000, random_pc(), '0, pick_operand(), xlen_t'($urandom % 4096),
               '0, 1'b0, '0, 0);
    end
    run_insn(OPC_JALR, 3'b000, 32'h0000_0900, '0, 32'h0000_1001, '0, '0, 1'b0, '0, 0);
    run_insn(OPC_JALR, 3'b000, 32'h0000_0904, '0, 32'h0000_1003, '0, '0, 1'b0, '0, 0);

    // Same taken branch trains its counter before one not-taken instance
    kept_before = kept_pred;
    for (int i = 0; i < 6; i++) begin
      run_insn(OPC_BRANCH, BEQ, 32'h0000_0340, 32'h40, 32'h5, 32'h5, '0, 1'b0, '0, 0);
    end
    if (kept_pred == kept_before) begin
      errors++;
      $display("Repeated taken branch still flushed on every instance after training");
    end
    run_insn(OPC_BRANCH, BEQ, 32'h0000_0340, 32'h40, 32'h5, 32'h6, '0, 1'b0, '0, 0);

    // FENCE.I
    run_insn(OPC_MISC_MEM, 3'b001, 32'h0000_0a00, '0, '0, '0, '0, 1'b0, '0, 0);
    run_insn(OPC_MISC_MEM, 3'b001, random_pc(), '0, '0, '0, '0, 1'b0, '0, 0);

    // Decode exceptions passed through or squashed
    run_insn(OPC_OTHER, 3'b000, 32'h0000_0500, '0, '0, '0, make_exc(1'b1, 1'b0), 1'b0, '0, 0);
    run_insn(OPC_OTHER, 3'b000, 32'h0000_0504, '0, '0, '0, make_exc(1'b0, 1'b1), 1'b0, '0, 0);
    run_insn(OPC_OTHER, 3'b000, 32'h0000_0508, '0, '0, '0, make_exc(1'b1, 1'b0), 1'b1, '0, 0);
    for (int s = 0; s < 3; s++) begin
      run_insn(OPC_OTHER, 3'b000, 32'h0000_0510, '0, '0, '0, make_exc(1'b0, 1'b1), 1'b0,
               make_exc(1'b1, 1'b0), s);
    end
    flush_then_exc(32'h0000_0600, 32'h0000_2001, 32'h10);

    stall_hold(32'h0000_0700);

    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < 16) begin
      @(posedge clk_i);
      wait_cnt++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Timed out with %0d expected results never compared", exp_q.size());
    end

    $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
             checks, errors, i_dut.i_properties.assert_fails);
    if (errors == 0 && i_dut.i_properties.assert_fails == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Hard limit on simulated time
  initial begin : watchdog
    #1_000_000;
    $display("Run did not complete within 1 ms of simulated time");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: flist.f
+incdir+logic
logic/bru_pkg.sv
logic/bru_gshare.sv
logic/bru_branch_unit.sv
logic/bru_top.sv
dv/bru_properties.sv
dv/bru_tb.sv

// File: logic/bru_branch_unit.sv
`timescale 1ns/1ps
`include "bru_cfg.svh"

module bru_branch_unit (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  ex_stall_i,
  input  logic                  st_flush_i,
  input  bru_pkg::xlen_t        id_pc_i,
  input  bru_pkg::bp_info_t     id_bp_i,
  input  bru_pkg::insn_t        id_insn_i,
  input  bru_pkg::exceptions_t  id_exceptions_i,
  input  bru_pkg::exceptions_t  ex_exceptions_i,
  input  bru_pkg::exceptions_t  mem_exceptions_i,
  input  bru_pkg::exceptions_t  wb_exceptions_i,
  input  bru_pkg::xlen_t        opa_i,
  input  bru_pkg::xlen_t        opb_i,
  output bru_pkg::xlen_t        nxt_pc_o,
  output logic                  flush_o,
  output logic                  cacheflush_o,
  output bru_pkg::bp_cnt_t      bp_predict_o,
  output bru_pkg::bp_hist_t     bp_history_update_o,
  output bru_pkg::bp_hist_t     bp_history_o,
  output logic                  bp_btaken_o,
  output logic                  bp_update_o,
  output bru_pkg::exceptions_t  exceptions_o
);

  import bru_pkg::*;

  localparam logic rvc_en = (`HAS_RVC != 0);

  opcode_e     opcode;
  branch_f3_e  br_f3;
  logic [2:0]  funct3;
  logic        is_16bit;
  xlen_t       seq_step;
  xlen_t       seq_pc;
  xlen_t       ext_imm_j;
  xlen_t       ext_imm_b;

  // Resolution results, registered below
  logic        cond;
  logic        btaken;
  logic        bp_update;
  logic        pipeflush;
  logic        cacheflush;
  xlen_t       nxt_pc;

  logic        target_misaligned;
  logic        misaligned;
  logic        kill_exc;
  exceptions_t exc_merged;

  // One extra bit, the newest outcome is kept out of the lookup
  logic [`BP_GLOBAL_BITS:0] bp_history;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  assign opcode    = insn_opcode(id_insn_i.instr);
  assign funct3    = insn_funct3(id_insn_i.instr);
  assign br_f3     = branch_f3_e'(funct3);
  assign ext_imm_j = imm_j(id_insn_i.instr);
  assign ext_imm_b = imm_b(id_insn_i.instr);

  // Compressed encodings have low bits other than 2'b11
  assign is_16bit  = ~&id_insn_i.instr[1:0];
  assign seq_step  = (rvc_en && is_16bit) ? xlen_t'(2) : xlen_t'(4);
  assign seq_pc    = id_pc_i + seq_step;

  // Branch condition per funct3
  always_comb begin
    case (br_f3)
      BEQ:     cond = (opa_i == opb_i);
      BNE:     cond = (opa_i != opb_i);
      BLT:     cond = ($signed(opa_i) <  $signed(opb_i));
      BGE:     cond = ($signed(opa_i) >= $signed(opb_i));
      BLTU:    cond = (opa_i <  opb_i);
      BGEU:    cond = (opa_i >= opb_i);
      default: cond = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control transfer resolution
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Sequential, no flush, unless overridden
    btaken     = 1'b0;
    bp_update  = 1'b0;
    pipeflush  = 1'b0;
    cacheflush = 1'b0;
    nxt_pc     = seq_pc;

    if (!id_insn_i.bubble) begin
      case (opcode)
        OPC_JAL: begin
          btaken    = 1'b1;
          // Fetch already redirected when predicted taken
          pipeflush = ~id_bp_i.predict[1];
          nxt_pc    = id_pc_i + ext_imm_j;
        end
        OPC_JALR: begin
          btaken    = 1'b1;
          // Target unknown at fetch, always redirect
          pipeflush = 1'b1;
          nxt_pc    = (opa_i + opb_i) & ~xlen_t'(1);
        end
        OPC_BRANCH: begin
          btaken    = cond;
          bp_update = 1'b1;
          // Mispredict in either direction
          pipeflush = cond ^ id_bp_i.predict[1];
          nxt_pc    = cond ? id_pc_i + ext_imm_b : seq_pc;
        end
        OPC_MISC_MEM: begin
          if (funct3 == F3_FENCE_I) begin
            pipeflush  = 1'b1;
            cacheflush = 1'b1;
            nxt_pc     = id_pc_i + xlen_t'(4);
          end
        end
        default: begin
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Exceptions
  ////////////////////////////////////////////////////////////////////////////

  // 2-byte alignment with RVC, 4-byte otherwise
  always_comb begin
    target_misaligned = 1'b0;
    if (!id_insn_i.bubble && (opcode inside {OPC_JAL, OPC_JALR, OPC_BRANCH})) begin
      target_misaligned = rvc_en ? nxt_pc[0] : |nxt_pc[1:0];
    end
  end

  assign misaligned = id_exceptions_i.misaligned_instruction | target_misaligned;

  always_comb begin
    exc_merged                        = id_exceptions_i;
    exc_merged.misaligned_instruction = misaligned;
    exc_merged.any                    = id_exceptions_i.any | misaligned;
  end

  // Instruction is squashed, or an older one already trapped
  assign kill_exc = flush_o | st_flush_i |
                    ex_exceptions_i.any | mem_exceptions_i.any | wb_exceptions_i.any;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exceptions_o <= '0;
    end else if (!ex_stall_i) begin
      exceptions_o <= kill_exc ? '0 : exc_merged;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registered outputs
  ////////////////////////////////////////////////////////////////////////////

  // Flush and training strobes run every cycle
  // Pipeline restarts out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_o             <= 1'b1;
      cacheflush_o        <= 1'b0;
      bp_predict_o        <= '0;
      bp_btaken_o         <= 1'b0;
      bp_update_o         <= 1'b0;
      bp_history_update_o <= '0;
      bp_history          <= '0;
    end else begin
      flush_o             <= pipeflush;
      cacheflush_o        <= cacheflush;
      bp_predict_o        <= id_bp_i.predict;
      bp_btaken_o         <= btaken;
      bp_update_o         <= bp_update;
      bp_history_update_o <= id_bp_i.history;
      // Speculative history, conditional branches only
      if (bp_update) begin
        bp_history <= {bp_history[`BP_GLOBAL_BITS-1:0], btaken};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nxt_pc_o <= xlen_t'(`PC_INIT);
    end else if (!ex_stall_i) begin
      nxt_pc_o <= nxt_pc;
    end
  end

  // Lookup history leaves out the branch just resolved
  assign bp_history_o = bp_history[`BP_GLOBAL_BITS:1];

endmodule

// File: logic/bru_cfg.svh
`ifndef BRU_CFG_SVH
`define BRU_CFG_SVH

// Data and address width
`define XLEN 32

// Next PC after reset
`define PC_INIT 'h200

// Global history length of the gshare predictor
`define BP_GLOBAL_BITS 2

// Pattern history table index width, 64 counters
`define BP_PHT_BITS 6

// Compressed instruction support
// 1 allows 2-byte sequential steps and 2-byte target alignment
`define HAS_RVC 0

`endif

// File: logic/bru_gshare.sv
`timescale 1ns/1ps
`include "bru_cfg.svh"

module bru_gshare (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               ex_stall_i,
  input  bru_pkg::xlen_t     if_pc_i,
  input  bru_pkg::bp_hist_t  bu_history_i,
  input  logic               bu_update_i,
  input  logic               bu_btaken_i,
  input  bru_pkg::bp_hist_t  bu_history_update_i,
  output bru_pkg::xlen_t     id_pc_o,
  output bru_pkg::bp_info_t  id_bp_o
);

  import bru_pkg::*;

  localparam int pht_depth = 1 << `BP_PHT_BITS;

  typedef logic [`BP_PHT_BITS-1:0] pht_idx_t;

  // Table of 2-bit counters
  bp_cnt_t  pht [pht_depth];

  pht_idx_t rd_idx;
  pht_idx_t wr_idx;
  bp_cnt_t  cnt_cur;
  bp_cnt_t  cnt_next;

  // PC of the instruction now in execute
  xlen_t    ex_pc;

  // Word address bits XOR history, history zero extended
  function automatic pht_idx_t pht_hash(xlen_t pc, bp_hist_t hist);
    return pc[`BP_PHT_BITS+1:2] ^ pht_idx_t'(hist);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Lookup and decode register
  ////////////////////////////////////////////////////////////////////////////

  // Fetch PC hashed with the live history from the branch unit
  assign rd_idx = pht_hash(if_pc_i, bu_history_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_pc_o <= '0;
      id_bp_o <= '0;
    end else if (!ex_stall_i) begin
      id_pc_o         <= if_pc_i;
      id_bp_o.predict <= pht[rd_idx];
      // Keep the history used, training must hit the same entry
      id_bp_o.history <= bu_history_i;
    end
  end

  // Second PC stage, lines up with the branch unit's training strobes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex_pc <= '0;
    end else if (!ex_stall_i) begin
      ex_pc <= id_pc_o;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Training
  ////////////////////////////////////////////////////////////////////////////

  assign wr_idx  = pht_hash(ex_pc, bu_history_update_i);
  assign cnt_cur = pht[wr_idx];

  // Saturating step toward the resolved direction
  always_comb begin
    if (bu_btaken_i) begin
      cnt_next = (cnt_cur == 2'b11) ? cnt_cur : cnt_cur + 2'd1;
    end else begin
      cnt_next = (cnt_cur == 2'b00) ? cnt_cur : cnt_cur - 2'd1;
    end
  end

  // All counters start weakly not-taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < pht_depth; i++) begin
        pht[i] <= 2'b01;
      end
    end else if (bu_update_i) begin
      pht[wr_idx] <= cnt_next;
    end
  end

endmodule

// File: logic/bru_pkg.sv
`include "bru_cfg.svh"

package bru_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Basic vector types
  ////////////////////////////////////////////////////////////////////////////

  // Data and address word
  typedef logic [`XLEN-1:0]           xlen_t;

  // Global branch history
  typedef logic [`BP_GLOBAL_BITS-1:0] bp_hist_t;

  // 2-bit saturating counter, MSB set means predict taken
  typedef logic [1:0]                 bp_cnt_t;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encodings
  ////////////////////////////////////////////////////////////////////////////

  // Major opcodes handled by the branch unit
  // Everything else folds onto OPC_OTHER
  typedef enum logic [6:0] {
    OPC_BRANCH   = 7'b1100011,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_MISC_MEM = 7'b0001111,
    OPC_OTHER    = 7'b0000000
  } opcode_e;

  // Conditional branch kinds, funct3 field
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_f3_e;

  // funct3 of FENCE.I under MISC_MEM
  localparam logic [2:0] F3_FENCE_I = 3'b001;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline structs
  ////////////////////////////////////////////////////////////////////////////

  // Instruction as it leaves decode
  typedef struct packed {
    logic        bubble;
    logic [31:0] instr;
  } insn_t;

  // Exception flags, any is the summary
  typedef struct packed {
    logic illegal_instruction;
    logic misaligned_instruction;
    logic breakpoint;
    logic any;
  } exceptions_t;

  // Prediction carried from the predictor's decode register
  typedef struct packed {
    bp_cnt_t  predict;
    bp_hist_t history;
  } bp_info_t;

  ////////////////////////////////////////////////////////////////////////////
  // Field decoders
  ////////////////////////////////////////////////////////////////////////////

  // Unknown major opcodes map to OPC_OTHER
  function automatic opcode_e insn_opcode(logic [31:0] instr);
    case (instr[6:0])
      OPC_BRANCH, OPC_JAL, OPC_JALR, OPC_MISC_MEM: return opcode_e'(instr[6:0]);
      default:                                   return OPC_OTHER;
    endcase
  endfunction

  function automatic logic [2:0] insn_funct3(logic [31:0] instr);
    return instr[14:12];
  endfunction

  // J-type immediate, sign extended to XLEN
  function automatic xlen_t imm_j(logic [31:0] instr);
    logic [20:0] imm;
    imm = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    return {{(`XLEN-21){imm[20]}}, imm};
  endfunction

  // B-type immediate, sign extended to XLEN
  function automatic xlen_t imm_b(logic [31:0] instr);
    logic [12:0] imm;
    imm = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    return {{(`XLEN-13){imm[12]}}, imm};
  endfunction

endpackage

// File: logic/bru_top.sv
`timescale 1ns/1ps

module bru_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  ex_stall_i,
  input  logic                  st_flush_i,
  input  bru_pkg::xlen_t        if_pc_i,
  input  bru_pkg::insn_t        id_insn_i,
  input  bru_pkg::exceptions_t  id_exceptions_i,
  input  bru_pkg::exceptions_t  ex_exceptions_i,
  input  bru_pkg::exceptions_t  mem_exceptions_i,
  input  bru_pkg::exceptions_t  wb_exceptions_i,
  input  bru_pkg::xlen_t        opa_i,
  input  bru_pkg::xlen_t        opb_i,
  output bru_pkg::xlen_t        nxt_pc_o,
  output logic                  flush_o,
  output logic                  cacheflush_o,
  output logic                  bp_btaken_o,
  output logic                  bp_update_o,
  output bru_pkg::exceptions_t  exceptions_o
);

  import bru_pkg::*;

  // Decode stage view from the predictor
  xlen_t    id_pc;
  bp_info_t id_bp;

  // Training loop back to the table
  bp_hist_t bp_history;
  bp_hist_t bp_history_update;

  bru_gshare i_gshare (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .ex_stall_i          (ex_stall_i),
    .if_pc_i             (if_pc_i),
    .bu_history_i        (bp_history),
    .bu_update_i         (bp_update_o),
    .bu_btaken_i         (bp_btaken_o),
    .bu_history_update_i (bp_history_update),
    .id_pc_o             (id_pc),
    .id_bp_o             (id_bp)
  );

  // Counter echo is left open, the table rereads its own entry
  bru_branch_unit i_branch_unit (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .ex_stall_i          (ex_stall_i),
    .st_flush_i          (st_flush_i),
    .id_pc_i             (id_pc),
    .id_bp_i             (id_bp),
    .id_insn_i           (id_insn_i),
    .id_exceptions_i     (id_exceptions_i),
    .ex_exceptions_i     (ex_exceptions_i),
    .mem_exceptions_i    (mem_exceptions_i),
    .wb_exceptions_i     (wb_exceptions_i),
    .opa_i               (opa_i),
    .opb_i               (opb_i),
    .nxt_pc_o            (nxt_pc_o),
    .flush_o             (flush_o),
    .cacheflush_o        (cacheflush_o),
    .bp_predict_o        (),
    .bp_history_update_o (bp_history_update),
    .bp_history_o        (bp_history),
    .bp_btaken_o         (bp_btaken_o),
    .bp_update_o         (bp_update_o),
    .exceptions_o        (exceptions_o)
  );

endmodule
